/* verilog/tpu_pkg.sv */
package tpu_pkg;

    // array geometry
    localparam int ARRAY_SIZE = 4;

    // datapath widths
    localparam int DATA_WIDTH = 8;   // activations and weights
    localparam int ACC_WIDTH  = 32;  // partial and accumulated sums

    // accumulator store
    localparam int ACC_DEPTH  = 16;
    localparam int ADDR_WIDTH = $clog2(ACC_DEPTH);

    // scalar element types
    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

    // one element per array row or column, element 0 in the low bits
    typedef data_t [ARRAY_SIZE-1:0] data_vec_t;
    typedef acc_t  [ARRAY_SIZE-1:0] acc_vec_t;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [ARRAY_SIZE-1:0] mask_t;  // bit j enables column j

endpackage

/* verilog/tpu_ctrl_pkg.sv */
package tpu_ctrl_pkg;

    // host command opcodes
    typedef enum logic [1:0] {
        OP_NOP          = 2'd0,
        OP_LOAD_WEIGHTS = 2'd1,  // cmd_data_i is one weight row
        OP_MATMUL       = 2'd2,  // cmd_data_i is one activation vector
        OP_READ         = 2'd3
    } opcode_e;

    typedef enum logic [1:0] {
        SEQ_IDLE   = 2'd0,
        SEQ_STREAM = 2'd1,  // matmuls arriving
        SEQ_DRAIN  = 2'd2   // last results still moving through
    } seq_state_e;

    // activation entering the array until column 0's sum leaves it
    localparam int ARRAY_LATENCY = tpu_pkg::ARRAY_SIZE + 1;

    // last matmul command until its last column is written
    localparam int DRAIN_CYCLES = 2 * tpu_pkg::ARRAY_SIZE + 2;

    typedef logic [$clog2(DRAIN_CYCLES)-1:0] drain_cnt_t;

endpackage

/* verilog/acc_wr_if.sv */
// write path into the accumulator
// control is aligned with column 0, column j's sum follows j cycles later
interface acc_wr_if;

    logic              wr_en;       // column 0 sum is valid this cycle
    tpu_pkg::addr_t    addr;        // target row
    logic              accumulate;  // add to stored word, else overwrite
    tpu_pkg::mask_t    mask;
    tpu_pkg::acc_vec_t col_sum;     // skewed column sums from the array

    modport ctrl (
        output wr_en,
        output addr,
        output accumulate,
        output mask
    );

    modport array (
        output col_sum
    );

    modport acc (
        input wr_en,
        input addr,
        input accumulate,
        input mask,
        input col_sum
    );

endinterface

/* verilog/mac_cell.sv */
module mac_cell (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           w_load_i,
    input  tpu_pkg::data_t w_i,
    input  tpu_pkg::data_t a_i,
    output tpu_pkg::data_t a_o,
    input  tpu_pkg::acc_t  psum_i,
    output tpu_pkg::acc_t  psum_o
);

    tpu_pkg::data_t                          w_q;   // stationary weight
    logic signed [2*tpu_pkg::DATA_WIDTH-1:0] prod;

    // full precision product, sign extended below
    assign prod = w_q * a_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            w_q <= '0;
        end else if (w_load_i) begin
            w_q <= w_i;
        end
    end

    // activation moves right, partial sum moves down
    always_ff @(posedge clk_i) begin
        a_o    <= a_i;
        psum_o <= psum_i + tpu_pkg::acc_t'(prod);
    end

endmodule

/* verilog/systolic_array.sv */
module systolic_array (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  weight_load_i,
    input  logic [$clog2(tpu_pkg::ARRAY_SIZE)-1:0] weight_row_i,
    input  tpu_pkg::data_vec_t                    weight_data_i,
    input  logic                                  act_valid_i,
    input  tpu_pkg::data_vec_t                    act_data_i,
    acc_wr_if.array                               acc_wr
);

    // a_h[i][j] feeds cell (i,j) from the left, last column spills out
    tpu_pkg::data_t a_h [tpu_pkg::ARRAY_SIZE][tpu_pkg::ARRAY_SIZE+1];
    // p_v[i][j] feeds cell (i,j) from above, row ARRAY_SIZE is the result
    tpu_pkg::acc_t  p_v [tpu_pkg::ARRAY_SIZE+1][tpu_pkg::ARRAY_SIZE];

    logic [tpu_pkg::ARRAY_SIZE-1:0] row_sel;  // one-hot weight row strobe

    always_comb begin
        row_sel = '0;
        if (weight_load_i) begin
            row_sel[weight_row_i] = 1'b1;
        end
    end

    for (genvar i = 0; i < tpu_pkg::ARRAY_SIZE; i++) begin : g_row
        // stage 0 is the input register, then i more stages of skew
        tpu_pkg::data_t skew_q [i+1];

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                for (int k = 0; k <= i; k++) begin
                    skew_q[k] <= '0;
                end
            end else begin
                skew_q[0] <= act_valid_i ? act_data_i[i] : '0;  // bubble feeds zero
                for (int k = 1; k <= i; k++) begin
                    skew_q[k] <= skew_q[k-1];
                end
            end
        end

        assign a_h[i][0] = skew_q[i];

        for (genvar j = 0; j < tpu_pkg::ARRAY_SIZE; j++) begin : g_col
            mac_cell u_cell (
                .clk_i    (clk_i),
                .rst_i    (rst_i),
                .w_load_i (row_sel[i]),
                .w_i      (weight_data_i[j]),
                .a_i      (a_h[i][j]),
                .a_o      (a_h[i][j+1]),
                .psum_i   (p_v[i][j]),
                .psum_o   (p_v[i+1][j])
            );
        end
    end

    for (genvar j = 0; j < tpu_pkg::ARRAY_SIZE; j++) begin : g_edge
        assign p_v[0][j]          = '0;  // nothing above the top row
        assign acc_wr.col_sum[j]  = p_v[tpu_pkg::ARRAY_SIZE][j];
    end

endmodule

/* verilog/accumulator.sv */
module accumulator (
    input  logic              clk_i,
    input  logic              rst_i,
    acc_wr_if.acc             acc_wr,
    input  logic              rd_en_i,
    input  tpu_pkg::addr_t    rd_addr_i,
    output tpu_pkg::acc_vec_t rd_data_o,
    output logic              rd_valid_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    // one bank per column
    // control for column j is delayed j cycles behind column 0,
    // plus one input stage shared with the sum register
    for (genvar j = 0; j < tpu_pkg::ARRAY_SIZE; j++) begin : g_bank
        logic [j:0]     we_q;
        logic [j:0]     accum_q;
        logic [j:0]     mask_q;
        tpu_pkg::addr_t addr_q [j+1];
        tpu_pkg::acc_t  sum_q;
        tpu_pkg::acc_t  rd_q;
        tpu_pkg::acc_t  mem [tpu_pkg::ACC_DEPTH];

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                we_q <= '0;
            end else begin
                we_q[0] <= acc_wr.wr_en;
                for (int k = 1; k <= j; k++) begin
                    we_q[k] <= we_q[k-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            addr_q[0]  <= acc_wr.addr;
            accum_q[0] <= acc_wr.accumulate;
            mask_q[0]  <= acc_wr.mask[j];
            for (int k = 1; k <= j; k++) begin
                addr_q[k]  <= addr_q[k-1];
                accum_q[k] <= accum_q[k-1];
                mask_q[k]  <= mask_q[k-1];
            end
            sum_q <= acc_wr.col_sum[j];  // already j cycles late from the array
        end

        // read-modify-write in one cycle keeps same-row accumulates in order
        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                for (int r = 0; r < tpu_pkg::ACC_DEPTH; r++) begin
                    mem[r] <= '0;
                end
            end else if (we_q[j] && mask_q[j]) begin
                mem[addr_q[j]] <= accum_q[j] ? mem[addr_q[j]] + sum_q : sum_q;
            end
        end

        always_ff @(posedge clk_i) begin
            if (rd_en_i) begin
                rd_q <= mem[rd_addr_i];
            end
        end

        assign rd_data_o[j] = rd_q;
    end

endmodule

/* verilog/tpu_sequencer.sv */
module tpu_sequencer (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  cmd_valid_i,
    input  tpu_ctrl_pkg::opcode_e                 cmd_op_i,
    input  tpu_pkg::addr_t                        cmd_addr_i,
    input  tpu_pkg::mask_t                        cmd_mask_i,
    input  logic                                  cmd_acc_i,
    input  tpu_pkg::data_vec_t                    cmd_data_i,
    output logic                                  weight_load_o,
    output logic [$clog2(tpu_pkg::ARRAY_SIZE)-1:0] weight_row_o,
    output tpu_pkg::data_vec_t                    weight_data_o,
    output logic                                  act_valid_o,
    output tpu_pkg::data_vec_t                    act_data_o,
    acc_wr_if.ctrl                                acc_wr,
    output logic                                  rd_en_o,
    output tpu_pkg::addr_t                        rd_addr_o,
    output logic                                  busy_o
);

    // registered command
    logic                  cmd_valid_q;
    tpu_ctrl_pkg::opcode_e cmd_op_q;
    tpu_pkg::addr_t        cmd_addr_q;
    tpu_pkg::mask_t        cmd_mask_q;
    logic                  cmd_acc_q;
    tpu_pkg::data_vec_t    cmd_data_q;

    logic do_load;
    logic do_mm;
    logic do_rd;

    // write control delay, last stage lines up with column 0's sum
    logic [tpu_ctrl_pkg::ARRAY_LATENCY-1:0] mm_we_q;
    logic [tpu_ctrl_pkg::ARRAY_LATENCY-1:0] mm_acc_q;
    tpu_pkg::addr_t                         mm_addr_q [tpu_ctrl_pkg::ARRAY_LATENCY];
    tpu_pkg::mask_t                         mm_mask_q [tpu_ctrl_pkg::ARRAY_LATENCY];

    tpu_ctrl_pkg::seq_state_e state_q;
    tpu_ctrl_pkg::seq_state_e state_d;
    tpu_ctrl_pkg::drain_cnt_t drain_q;
    tpu_ctrl_pkg::drain_cnt_t drain_d;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= cmd_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        cmd_op_q   <= cmd_op_i;
        cmd_addr_q <= cmd_addr_i;
        cmd_mask_q <= cmd_mask_i;
        cmd_acc_q  <= cmd_acc_i;
        cmd_data_q <= cmd_data_i;
    end

    always_comb begin
        do_load = 1'b0;
        do_mm   = 1'b0;
        do_rd   = 1'b0;
        if (cmd_valid_q) begin
            case (cmd_op_q)
                tpu_ctrl_pkg::OP_NOP:          ;
                tpu_ctrl_pkg::OP_LOAD_WEIGHTS: do_load = 1'b1;
                tpu_ctrl_pkg::OP_MATMUL:       do_mm   = 1'b1;
                tpu_ctrl_pkg::OP_READ:         do_rd   = 1'b1;
            endcase
        end
    end

    // weights and activations go straight out of the command register
    assign weight_load_o = do_load;
    assign weight_row_o  = cmd_addr_q[$clog2(tpu_pkg::ARRAY_SIZE)-1:0];
    assign weight_data_o = cmd_data_q;
    assign act_valid_o   = do_mm;
    assign act_data_o    = cmd_data_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mm_we_q <= '0;
        end else begin
            mm_we_q <= {mm_we_q[tpu_ctrl_pkg::ARRAY_LATENCY-2:0], do_mm};
        end
    end

    always_ff @(posedge clk_i) begin
        mm_acc_q     <= {mm_acc_q[tpu_ctrl_pkg::ARRAY_LATENCY-2:0], cmd_acc_q};
        mm_addr_q[0] <= cmd_addr_q;
        mm_mask_q[0] <= cmd_mask_q;
        for (int k = 1; k < tpu_ctrl_pkg::ARRAY_LATENCY; k++) begin
            mm_addr_q[k] <= mm_addr_q[k-1];
            mm_mask_q[k] <= mm_mask_q[k-1];
        end
    end

    assign acc_wr.wr_en      = mm_we_q[tpu_ctrl_pkg::ARRAY_LATENCY-1];
    assign acc_wr.accumulate = mm_acc_q[tpu_ctrl_pkg::ARRAY_LATENCY-1];
    assign acc_wr.addr       = mm_addr_q[tpu_ctrl_pkg::ARRAY_LATENCY-1];
    assign acc_wr.mask       = mm_mask_q[tpu_ctrl_pkg::ARRAY_LATENCY-1];

    // read strobe gets one stage here, the accumulator adds the other
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_en_o <= 1'b0;
        end else begin
            rd_en_o <= do_rd;
        end
    end

    always_ff @(posedge clk_i) begin
        rd_addr_o <= cmd_addr_q;
    end

    // each matmul restarts the drain count
    always_comb begin
        state_d = state_q;
        drain_d = drain_q;
        if (do_mm) begin
            state_d = tpu_ctrl_pkg::SEQ_STREAM;
            drain_d = tpu_ctrl_pkg::drain_cnt_t'(tpu_ctrl_pkg::DRAIN_CYCLES - 1);
        end else begin
            case (state_q)
                tpu_ctrl_pkg::SEQ_IDLE: ;
                tpu_ctrl_pkg::SEQ_STREAM, tpu_ctrl_pkg::SEQ_DRAIN: begin
                    if (drain_q == '0) begin
                        state_d = tpu_ctrl_pkg::SEQ_IDLE;  // last column written
                    end else begin
                        state_d = tpu_ctrl_pkg::SEQ_DRAIN;
                        drain_d = drain_q - 1'b1;
                    end
                end
                default: state_d = tpu_ctrl_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= tpu_ctrl_pkg::SEQ_IDLE;
            drain_q <= '0;
        end else begin
            state_q <= state_d;
            drain_q <= drain_d;
        end
    end

    assign busy_o = (state_q != tpu_ctrl_pkg::SEQ_IDLE);

endmodule

/* verilog/tpu_top.sv */
module tpu_top (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  cmd_valid_i,
    input  tpu_ctrl_pkg::opcode_e cmd_op_i,
    input  tpu_pkg::addr_t        cmd_addr_i,
    input  tpu_pkg::mask_t        cmd_mask_i,
    input  logic                  cmd_acc_i,
    input  tpu_pkg::data_vec_t    cmd_data_i,
    output logic                  busy_o,
    output logic                  rd_valid_o,
    output tpu_pkg::acc_vec_t     rd_data_o
);

    // sequencer to array
    logic                                  weight_load;
    logic [$clog2(tpu_pkg::ARRAY_SIZE)-1:0] weight_row;
    tpu_pkg::data_vec_t                    weight_data;
    logic                                  act_valid;
    tpu_pkg::data_vec_t                    act_data;

    // sequencer to accumulator read port
    logic           rd_en;
    tpu_pkg::addr_t rd_addr;

    acc_wr_if acc_wr_bus ();

    tpu_sequencer u_seq (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_op_i      (cmd_op_i),
        .cmd_addr_i    (cmd_addr_i),
        .cmd_mask_i    (cmd_mask_i),
        .cmd_acc_i     (cmd_acc_i),
        .cmd_data_i    (cmd_data_i),
        .weight_load_o (weight_load),
        .weight_row_o  (weight_row),
        .weight_data_o (weight_data),
        .act_valid_o   (act_valid),
        .act_data_o    (act_data),
        .acc_wr        (acc_wr_bus),
        .rd_en_o       (rd_en),
        .rd_addr_o     (rd_addr),
        .busy_o        (busy_o)
    );

    systolic_array u_array (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .weight_load_i (weight_load),
        .weight_row_i  (weight_row),
        .weight_data_i (weight_data),
        .act_valid_i   (act_valid),
        .act_data_i    (act_data),
        .acc_wr        (acc_wr_bus)
    );

    accumulator u_acc (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .acc_wr     (acc_wr_bus),
        .rd_en_i    (rd_en),
        .rd_addr_i  (rd_addr),
        .rd_data_o  (rd_data_o),
        .rd_valid_o (rd_valid_o)
    );

endmodule

/* bench/tb_tpu.sv */
module tb_tpu;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int N            = tpu_pkg::ARRAY_SIZE;
    localparam int DEPTH        = tpu_pkg::ACC_DEPTH;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int BUSY_EDGES   = 2 * N + 3;  // matmul strobe until busy_o falls
    localparam int RANDOM_CMDS  = 300;
    // one term per test
    localparam int TOTAL_CMDS = DEPTH + (N + 24) + (12 + DEPTH) + (10 + DEPTH) + (N + 5)
                                + (RANDOM_CMDS + DEPTH);

    logic                  clk_i;
    logic                  rst_i;
    logic                  cmd_valid_i;
    tpu_ctrl_pkg::opcode_e cmd_op_i;
    tpu_pkg::addr_t        cmd_addr_i;
    tpu_pkg::mask_t        cmd_mask_i;
    logic                  cmd_acc_i;
    tpu_pkg::data_vec_t    cmd_data_i;
    logic                  busy_o;
    logic                  rd_valid_o;
    tpu_pkg::acc_vec_t     rd_data_o;

    integer             seed;
    logic               pending;            // matmul results may still be in flight
    tpu_pkg::data_vec_t w_model [N];        // w_model[i][j] sits in cell (i,j)
    tpu_pkg::acc_vec_t  acc_model [DEPTH];

    tpu_top uut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_op_i    (cmd_op_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_mask_i  (cmd_mask_i),
        .cmd_acc_i   (cmd_acc_i),
        .cmd_data_i  (cmd_data_i),
        .busy_o      (busy_o),
        .rd_valid_o  (rd_valid_o),
        .rd_data_o   (rd_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_row(input tpu_pkg::acc_vec_t got, input tpu_pkg::acc_vec_t exp,
                             input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t ns: %s read %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t ns: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic tpu_pkg::data_vec_t rand_vec();
        return tpu_pkg::data_vec_t'(rand_word());
    endfunction

    // sampled by the DUT at the following edge
    task automatic drive_cmd(input tpu_ctrl_pkg::opcode_e op, input tpu_pkg::addr_t addr,
                             input tpu_pkg::mask_t mask, input logic acc,
                             input tpu_pkg::data_vec_t data);
        @(posedge clk_i);
        cmd_valid_i <= 1'b1;
        cmd_op_i    <= op;
        cmd_addr_i  <= addr;
        cmd_mask_i  <= mask;
        cmd_acc_i   <= acc;
        cmd_data_i  <= data;
    endtask

    task automatic load_row(input int row, input tpu_pkg::data_vec_t data);
        drive_cmd(tpu_ctrl_pkg::OP_LOAD_WEIGHTS, tpu_pkg::addr_t'(row), '0, 1'b0, data);
        w_model[row] = data;
    endtask

    task automatic load_random_weights();
        for (int i = 0; i < N; i++) begin
            load_row(i, rand_vec());
        end
    endtask

    task automatic matmul(input tpu_pkg::addr_t addr, input tpu_pkg::mask_t mask,
                          input logic acc, input tpu_pkg::data_vec_t act);
        tpu_pkg::acc_t sum;
        drive_cmd(tpu_ctrl_pkg::OP_MATMUL, addr, mask, acc, act);
        pending = 1'b1;
        for (int j = 0; j < N; j++) begin
            sum = '0;
            for (int i = 0; i < N; i++) begin
                sum += tpu_pkg::acc_t'($signed(act[i])) * tpu_pkg::acc_t'($signed(w_model[i][j]));
            end
            if (mask[j]) begin
                acc_model[addr][j] = acc ? acc_model[addr][j] + sum : sum;  // wraps at 32 bits
            end
        end
    endtask

    // rd_valid_o must rise exactly two edges after the strobe edge
    task automatic read_row(input tpu_pkg::addr_t addr);
        drive_cmd(tpu_ctrl_pkg::OP_READ, addr, '0, 1'b0, '0);
        @(posedge clk_i);  // strobe edge
        cmd_valid_i <= 1'b0;
        @(negedge clk_i);
        check_flag(rd_valid_o, 1'b0, "rd_valid_o one cycle early");
        @(negedge clk_i);
        check_flag(rd_valid_o, 1'b0, "rd_valid_o after the first edge");
        @(negedge clk_i);
        check_flag(rd_valid_o, 1'b1, "rd_valid_o after the second edge");
        check_row(rd_data_o, acc_model[addr], $sformatf("row %0d", addr));
        @(negedge clk_i);
        check_flag(rd_valid_o, 1'b0, "rd_valid_o after the third edge");
    endtask

    task automatic read_all();
        for (int r = 0; r < DEPTH; r++) begin
            read_row(tpu_pkg::addr_t'(r));
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        cmd_valid_i <= 1'b0;  // last command is taken at this edge
        @(posedge clk_i);
        @(negedge clk_i);
        while (busy_o && cycles <= tpu_ctrl_pkg::DRAIN_CYCLES) begin
            @(negedge clk_i);
            cycles++;
        end
        if (busy_o) begin
            abort_run("busy_o stayed high long after the last matmul");
        end else begin
            pending = 1'b0;
        end
    endtask

    // isolated matmul, then a weight reload that must not touch the earlier row
    task automatic busy_timing();
        logic [31:0]    r;
        tpu_pkg::addr_t row_a;
        tpu_pkg::addr_t row_b;
        r = rand_word();
        row_a = r[3:0];
        row_b = row_a + 4'd1;
        matmul(row_a, '1, 1'b0, rand_vec());
        @(posedge clk_i);
        cmd_valid_i <= 1'b0;
        @(negedge clk_i);
        check_flag(busy_o, 1'b0, "busy_o in the strobe cycle");
        for (int k = 1; k <= BUSY_EDGES; k++) begin
            @(negedge clk_i);
            check_flag(busy_o, k < BUSY_EDGES, $sformatf("busy_o %0d edges after matmul", k));
        end
        pending = 1'b0;
        read_row(row_a);
        load_random_weights();
        matmul(row_b, '1, 1'b0, rand_vec());
        wait_idle();
        read_row(row_a);
        read_row(row_b);
    endtask

    initial begin : watchdog
        int limit_ns;
        limit_ns = (TOTAL_CMDS * (2 * N + 6) + RESET_CYCLES + 200) * CLK_PERIOD;
        #(limit_ns);
        abort_run("simulation timed out");
    end

    initial begin
        logic [31:0] r;
        seed        = 32'h91d2;
        pending     = 1'b0;
        rst_i       = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_op_i    = tpu_ctrl_pkg::OP_NOP;
        cmd_addr_i  = '0;
        cmd_mask_i  = '0;
        cmd_acc_i   = 1'b0;
        cmd_data_i  = '0;
        for (int i = 0; i < N; i++) begin
            w_model[i] = '0;
        end
        for (int r2 = 0; r2 < DEPTH; r2++) begin
            acc_model[r2] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_flag(busy_o, 1'b0, "busy_o after reset");
        check_flag(rd_valid_o, 1'b0, "rd_valid_o after reset");
        read_all();

        // overwrite into distinct rows, second pass replaces the first
        load_random_weights();
        for (int k = 0; k < 16; k++) begin
            matmul(tpu_pkg::addr_t'(k % 8), '1, 1'b0, rand_vec());
        end
        wait_idle();
        for (int k = 0; k < 8; k++) begin
            read_row(tpu_pkg::addr_t'(k));
        end

        // back to back accumulates, one row first, then spread out
        r = rand_word();
        for (int k = 0; k < 6; k++) begin
            matmul(r[3:0], '1, 1'b1, rand_vec());
        end
        for (int k = 0; k < 6; k++) begin
            r = rand_word();
            matmul(r[3:0], '1, 1'b1, rand_vec());
        end
        wait_idle();
        read_all();

        // random column masks
        for (int k = 0; k < 10; k++) begin
            r = rand_word();
            matmul(r[3:0], r[7:4], r[8], rand_vec());
        end
        wait_idle();
        read_all();

        busy_timing();

        // mixed run, loads and reads only once busy_o has dropped
        for (int n = 0; n < RANDOM_CMDS; n++) begin
            r = rand_word();
            if (r[1:0] == 2'd1 || r[1:0] == 2'd2) begin
                matmul(r[7:4], r[11:8], r[12], rand_vec());
            end else begin
                if (pending) begin
                    wait_idle();
                end
                if (r[1:0] == 2'd0) begin
                    load_row(int'(r[3:2]), rand_vec());
                end else begin
                    read_row(r[7:4]);
                end
            end
        end
        wait_idle();
        read_all();

        $display(">>> PASS");
        $finish;
    end

endmodule

/* vlog.f */
verilog/tpu_pkg.sv
verilog/tpu_ctrl_pkg.sv
verilog/acc_wr_if.sv
verilog/mac_cell.sv
verilog/systolic_array.sv
verilog/accumulator.sv
verilog/tpu_sequencer.sv
verilog/tpu_top.sv
bench/tb_tpu.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the tb_tpu simulation with Verilator
set -e
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing -f vlog.f --top-module tb_tpu -o tb_tpu_sim
./obj_dir/tb_tpu_sim | tee "$log"

if grep -q '^>>> PASS$' "$log"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
